//--- ntt_pw.f
verilog/ntt_pw_pkg.sv
verilog/pw_apb_regs.sv
verilog/pw_sequencer.sv
verilog/pw_mod_lane.sv
verilog/pw_writeback.sv
verilog/ntt_pw_top.sv
tests/ntt_pw_assert.sv
tests/ntt_pw_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the ntt_pw testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal \
    --top-module ntt_pw_tb --Mdir "$OBJ" -o ntt_pw_sim -f ntt_pw.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ/ntt_pw_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Result: FAILED" "$LOG"; then
    exit 1
fi
if ! grep -q "Result: PASSED" "$LOG"; then
    echo "No result line found in $LOG"
    exit 1
fi
exit 0

//--- tests/ntt_pw_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ntt_pw_tb;

    localparam int NUM_WORDS     = 64;
    localparam int MEM_DEPTH     = 1 << ntt_pw_pkg::ADDR_W;
    localparam int WRITE_LATENCY = 4;
    // Six runs of about 90 cycles each plus register traffic, with ample margin
    localparam int TIMEOUT_CYCLES = 2000;

    logic                    clk;
    logic                    reset_n = 1'b0;
    logic                    psel    = 1'b0;
    logic                    penable = 1'b0;
    logic                    pwrite  = 1'b0;
    ntt_pw_pkg::apb_addr_t   paddr   = '0;
    ntt_pw_pkg::apb_data_t   pwdata  = '0;
    ntt_pw_pkg::apb_data_t   prdata;
    logic                    pready;
    logic                    pslverr;
    ntt_pw_pkg::mem_req_t    a_rd;
    ntt_pw_pkg::mem_req_t    b_rd;
    ntt_pw_pkg::mem_req_t    c_rd;
    ntt_pw_pkg::mem_req_t    c_wr;
    ntt_pw_pkg::mem_word_t   a_data = '0;
    ntt_pw_pkg::mem_word_t   b_data = '0;
    ntt_pw_pkg::mem_word_t   c_data = '0;
    ntt_pw_pkg::mem_word_t   c_wr_data;
    logic                    done;

    // Memories, and the operand images each run starts from
    ntt_pw_pkg::mem_word_t   a_mem [MEM_DEPTH];
    ntt_pw_pkg::mem_word_t   b_mem [MEM_DEPTH];
    ntt_pw_pkg::mem_word_t   c_mem [MEM_DEPTH];
    ntt_pw_pkg::mem_word_t   a_img [NUM_WORDS];
    ntt_pw_pkg::mem_word_t   b_img [NUM_WORDS];
    ntt_pw_pkg::mem_word_t   c_img [NUM_WORDS];
    logic                    load_img = 1'b0;

    string                   cur_test = "reset";
    ntt_pw_pkg::pw_op_e      cur_op = ntt_pw_pkg::OP_MUL;
    ntt_pw_pkg::mem_addr_t   cur_a_base = '0;
    ntt_pw_pkg::mem_addr_t   cur_c_base = '0;
    ntt_pw_pkg::mem_addr_t   cur_b_base = '0;

    int                      cycle_cnt = 0;
    int                      errors = 0;
    int                      checks = 0;
    int                      tests = 0;
    int                      start_errs = 0;
    int                      writes_seen = 0;
    int                      done_seen = 0;
    int                      rd_cycle_q [$];
    ntt_pw_pkg::mem_addr_t   rd_off_q [$];
    int                      rd_cyc;
    ntt_pw_pkg::mem_addr_t   rd_off;
    ntt_pw_pkg::mem_addr_t   wr_off;
    ntt_pw_pkg::mem_word_t   exp_word;

    ntt_pw_top #(
        .NUM_WORDS (NUM_WORDS)
    ) DUT (
        .clk         (clk),
        .reset_n     (reset_n),
        .psel_i      (psel),
        .penable_i   (penable),
        .pwrite_i    (pwrite),
        .paddr_i     (paddr),
        .pwdata_i    (pwdata),
        .prdata_o    (prdata),
        .pready_o    (pready),
        .pslverr_o   (pslverr),
        .a_rd_o      (a_rd),
        .b_rd_o      (b_rd),
        .c_rd_o      (c_rd),
        .a_data_i    (a_data),
        .b_data_i    (b_data),
        .c_data_i    (c_data),
        .c_wr_o      (c_wr),
        .c_wr_data_o (c_wr_data),
        .done_o      (done)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    initial begin
        while (cycle_cnt < TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Result: FAILED");
        $finish;
    end

    // ========================================================================
    // Memory models, one-cycle read latency
    // ========================================================================
    always @(posedge clk) begin
        if (load_img) begin
            for (int i = 0; i < NUM_WORDS; i++) begin
                a_mem[cur_a_base + ntt_pw_pkg::mem_addr_t'(i)] <= a_img[i];
                b_mem[cur_b_base + ntt_pw_pkg::mem_addr_t'(i)] <= b_img[i];
                c_mem[cur_c_base + ntt_pw_pkg::mem_addr_t'(i)] <= c_img[i];
            end
        end
        if (a_rd.en) a_data <= a_mem[a_rd.addr];
        if (b_rd.en) b_data <= b_mem[b_rd.addr];
        if (c_rd.en) c_data <= c_mem[c_rd.addr];
        if (c_wr.en) c_mem[c_wr.addr] <= c_wr_data;
    end

    // ========================================================================
    // Reference model and checks
    // ========================================================================
    function automatic ntt_pw_pkg::coeff_t ref_coeff(input ntt_pw_pkg::pw_op_e op,
            input ntt_pw_pkg::coeff_t a, input ntt_pw_pkg::coeff_t b,
            input ntt_pw_pkg::coeff_t c);
        longint q;
        longint r;
        q = longint'(ntt_pw_pkg::PW_Q);
        case (op)
            ntt_pw_pkg::OP_MUL:    r = (longint'(a) * longint'(b)) % q;
            ntt_pw_pkg::OP_MULACC: r = (longint'(c) + longint'(a) * longint'(b)) % q;
            ntt_pw_pkg::OP_ADD:    r = (longint'(a) + longint'(b)) % q;
            default:               r = (longint'(a) + q - longint'(b)) % q;
        endcase
        return ntt_pw_pkg::coeff_t'(r);
    endfunction

    // Expected word, top bit of each slot stays zero
    function automatic ntt_pw_pkg::mem_word_t ref_word(input ntt_pw_pkg::pw_op_e op,
            input ntt_pw_pkg::mem_word_t aw, input ntt_pw_pkg::mem_word_t bw,
            input ntt_pw_pkg::mem_word_t cw);
        ntt_pw_pkg::mem_word_t w;
        w = '0;
        for (int i = 0; i < ntt_pw_pkg::LANES; i++) begin
            w[i*ntt_pw_pkg::SLOT_W +: ntt_pw_pkg::COEFF_W] = ref_coeff(op,
                aw[i*ntt_pw_pkg::SLOT_W +: ntt_pw_pkg::COEFF_W],
                bw[i*ntt_pw_pkg::SLOT_W +: ntt_pw_pkg::COEFF_W],
                cw[i*ntt_pw_pkg::SLOT_W +: ntt_pw_pkg::COEFF_W]);
        end
        return w;
    endfunction

    function automatic ntt_pw_pkg::mem_word_t rand_word();
        ntt_pw_pkg::mem_word_t w;
        w = '0;
        for (int i = 0; i < ntt_pw_pkg::LANES; i++) begin
            w[i*ntt_pw_pkg::SLOT_W +: ntt_pw_pkg::COEFF_W] =
                ntt_pw_pkg::coeff_t'($urandom % ntt_pw_pkg::PW_Q);
        end
        return w;
    endfunction

    function automatic ntt_pw_pkg::mem_word_t same_word(input ntt_pw_pkg::coeff_t v);
        ntt_pw_pkg::mem_word_t w;
        w = '0;
        for (int i = 0; i < ntt_pw_pkg::LANES; i++) begin
            w[i*ntt_pw_pkg::SLOT_W +: ntt_pw_pkg::COEFF_W] = v;
        end
        return w;
    endfunction

    task automatic check_eq(input string what, input logic [95:0] expected,
            input logic [95:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("Error in %s: %s expected 0x%0h, actual 0x%0h",
                     cur_test, what, expected, actual);
            errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string msg);
        checks++;
        assert (cond) else begin
            $display("Error in %s: %s", cur_test, msg);
            errors++;
        end
    endtask

    // Every write is matched against the read of the same offset
    always @(posedge clk) begin
        if (reset_n) begin
            if (a_rd.en) begin
                rd_cycle_q.push_back(cycle_cnt);
                rd_off_q.push_back(a_rd.addr - cur_a_base);
            end
            if (c_rd.en) begin
                check_true(cur_op == ntt_pw_pkg::OP_MULACC, "c was read outside an accumulate");
            end
            if (c_wr.en) begin
                writes_seen++;
                wr_off = c_wr.addr - cur_c_base;
                if (rd_cycle_q.size() == 0) begin
                    check_true(1'b0, "c write without a matching read");
                end else begin
                    rd_cyc = rd_cycle_q.pop_front();
                    rd_off = rd_off_q.pop_front();
                    check_eq("write latency", WRITE_LATENCY, cycle_cnt - rd_cyc);
                    check_eq("write offset", rd_off, wr_off);
                end
                if (int'(wr_off) < NUM_WORDS) begin
                    exp_word = ref_word(cur_op, a_img[wr_off], b_img[wr_off], c_img[wr_off]);
                    check_eq("c word", exp_word, c_wr_data);
                end else begin
                    check_true(1'b0, "c write outside the result region");
                end
            end
            if (done) done_seen++;
        end
    end

    // ========================================================================
    // APB transfers, setup cycle then access cycle
    // ========================================================================
    task automatic apb_write(input ntt_pw_pkg::apb_addr_t addr,
            input ntt_pw_pkg::apb_data_t data, output logic err);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);
        err = pslverr;
        check_eq("write pready", 1, pready);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic apb_read(input ntt_pw_pkg::apb_addr_t addr,
            output ntt_pw_pkg::apb_data_t data, output logic err);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);
        data = prdata;
        err  = pslverr;
        check_eq("read pready", 1, pready);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic start_test(input string name);
        cur_test    = name;
        start_errs  = errors;
        writes_seen = 0;
        done_seen   = 0;
    endtask

    task automatic report_test();
        tests++;
        if (errors == start_errs) begin
            $display("Test %-24s ok", cur_test);
        end else begin
            $display("Test %-24s %0d error(s)", cur_test, errors - start_errs);
        end
    endtask

    task automatic test_registers();
        logic                  err;
        ntt_pw_pkg::apb_data_t rdata;
        start_test("register access");
        apb_write(ntt_pw_pkg::REG_A_BASE, 32'h0000_1234, err);
        check_eq("A_BASE write pslverr", 0, err);
        apb_write(ntt_pw_pkg::REG_B_BASE, 32'h0000_2b6d, err);
        apb_write(ntt_pw_pkg::REG_C_BASE, 32'h0000_7fff, err);
        apb_read(ntt_pw_pkg::REG_A_BASE, rdata, err);
        check_eq("A_BASE readback", 32'h0000_1234, rdata);
        check_eq("mapped read pslverr", 0, err);
        apb_read(ntt_pw_pkg::REG_B_BASE, rdata, err);
        check_eq("B_BASE readback", 32'h0000_2b6d, rdata);
        apb_read(ntt_pw_pkg::REG_C_BASE, rdata, err);
        check_eq("C_BASE readback", 32'h0000_7fff, rdata);
        apb_read(ntt_pw_pkg::REG_STATUS, rdata, err);
        check_eq("STATUS after reset", 0, rdata);
        apb_read(8'h20, rdata, err);
        check_eq("unmapped read data", 0, rdata);
        check_eq("unmapped read pslverr", 1, err);
        apb_write(8'h14, 32'hffff_ffff, err);
        check_eq("unmapped write pslverr", 1, err);
        report_test();
    endtask

    // One complete run through the engine
    task automatic run_test(input string name, input ntt_pw_pkg::pw_mode_e mode,
            input logic acc, input ntt_pw_pkg::mem_addr_t a_base,
            input ntt_pw_pkg::mem_addr_t b_base, input ntt_pw_pkg::mem_addr_t c_base,
            input logic edges, input logic status_chk, input logic poke_ctrl);
        logic                  err;
        ntt_pw_pkg::apb_data_t rdata;
        ntt_pw_pkg::coeff_t    q_m1;
        q_m1 = ntt_pw_pkg::coeff_t'(ntt_pw_pkg::PW_Q - 1);
        start_test(name);
        case (mode)
            ntt_pw_pkg::PW_ADD: cur_op = ntt_pw_pkg::OP_ADD;
            ntt_pw_pkg::PW_SUB: cur_op = ntt_pw_pkg::OP_SUB;
            default: cur_op = acc ? ntt_pw_pkg::OP_MULACC : ntt_pw_pkg::OP_MUL;
        endcase
        cur_a_base = a_base;
        cur_b_base = b_base;
        cur_c_base = c_base;
        for (int i = 0; i < NUM_WORDS; i++) begin
            a_img[i] = rand_word();
            b_img[i] = rand_word();
            c_img[i] = rand_word();
        end
        if (edges) begin
            a_img[0] = same_word('0);
            b_img[0] = same_word(q_m1);
            a_img[1] = same_word(q_m1);
            b_img[1] = same_word(q_m1);
            a_img[2] = same_word(q_m1);
            b_img[2] = same_word('0);
            a_img[3] = same_word('0);
            b_img[3] = same_word('0);
        end
        load_img <= 1'b1;
        @(posedge clk);
        load_img <= 1'b0;

        apb_write(ntt_pw_pkg::REG_A_BASE, ntt_pw_pkg::apb_data_t'(a_base), err);
        apb_write(ntt_pw_pkg::REG_B_BASE, ntt_pw_pkg::apb_data_t'(b_base), err);
        apb_write(ntt_pw_pkg::REG_C_BASE, ntt_pw_pkg::apb_data_t'(c_base), err);
        apb_write(ntt_pw_pkg::REG_CTRL, {28'd0, acc, mode, 1'b1}, err);
        if (status_chk) begin
            apb_read(ntt_pw_pkg::REG_STATUS, rdata, err);
            check_eq("STATUS during run", 32'h1, rdata);
        end
        if (poke_ctrl) begin
            apb_write(ntt_pw_pkg::REG_CTRL, {28'd0, 1'b1, ntt_pw_pkg::PW_ADD, 1'b1}, err);
            apb_read(ntt_pw_pkg::REG_CTRL, rdata, err);
            check_eq("CTRL while busy", {28'd0, acc, mode, 1'b0}, rdata);
        end

        do @(posedge clk); while (done !== 1'b1);
        repeat (3) @(posedge clk);
        check_eq("done pulses", 1, done_seen);
        check_eq("words written", NUM_WORDS, writes_seen);
        check_true(rd_cycle_q.size() == 0, "reads left over without a matching write");
        if (status_chk) begin
            apb_read(ntt_pw_pkg::REG_STATUS, rdata, err);
            check_eq("STATUS after run", 32'h2, rdata);
        end
        report_test();
    endtask

    // ========================================================================
    // Test sequence
    // ========================================================================
    initial begin
        void'($urandom(32'h378a_42fe));
        repeat (2) @(posedge clk);
        reset_n <= 1'b1;
        @(posedge clk);

        test_registers();
        run_test("multiply", ntt_pw_pkg::PW_MUL, 1'b0,
                 15'h0100, 15'h0200, 15'h0300, 1'b0, 1'b0, 1'b0);
        run_test("multiply-accumulate", ntt_pw_pkg::PW_MUL, 1'b1,
                 15'h1000, 15'h2000, 15'h3000, 1'b0, 1'b0, 1'b0);
        run_test("add", ntt_pw_pkg::PW_ADD, 1'b0,
                 15'h0400, 15'h0500, 15'h0600, 1'b1, 1'b0, 1'b0);
        // Result region wraps past the top of the address space
        run_test("subtract", ntt_pw_pkg::PW_SUB, 1'b0,
                 15'h0700, 15'h0800, 15'h7fe0, 1'b1, 1'b0, 1'b0);
        run_test("timing and status", ntt_pw_pkg::PW_MUL, 1'b0,
                 15'h4000, 15'h4100, 15'h4200, 1'b0, 1'b1, 1'b0);
        run_test("ctrl write while busy", ntt_pw_pkg::PW_SUB, 1'b0,
                 15'h5000, 15'h5100, 15'h5200, 1'b1, 1'b0, 1'b1);

        $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/ntt_pw_assert.sv
`timescale 1ns/1ps
`default_nettype none

module ntt_pw_assert (
    input  wire                          clk,
    input  wire                          reset_n,
    input  wire                          busy_i,
    input  wire                          done_i,
    input  wire                          pready_i,
    input  wire ntt_pw_pkg::mem_req_t    a_rd_i,
    input  wire ntt_pw_pkg::mem_req_t    b_rd_i,
    input  wire ntt_pw_pkg::mem_req_t    c_rd_i,
    input  wire ntt_pw_pkg::mem_req_t    c_wr_i
);

    // Result writes belong to a run
    assert property (@(posedge clk) disable iff (!reset_n) c_wr_i.en |-> busy_i)
        else $error("c write issued while the engine is not busy");

    // Single-cycle done pulse
    assert property (@(posedge clk) disable iff (!reset_n) done_i |=> !done_i)
        else $error("done held high for more than one cycle");

    assert property (@(posedge clk) disable iff (!reset_n) pready_i)
        else $error("pready dropped low");

    // No memory traffic when idle
    assert property (@(posedge clk) disable iff (!reset_n)
        (a_rd_i.en || b_rd_i.en || c_rd_i.en) |-> busy_i)
        else $error("read requested while the engine is idle");

endmodule

bind ntt_pw_top ntt_pw_assert u_assert (
    .clk      (clk),
    .reset_n  (reset_n),
    .busy_i   (u_regs.busy_q),
    .done_i   (done_o),
    .pready_i (pready_o),
    .a_rd_i   (a_rd_o),
    .b_rd_i   (b_rd_o),
    .c_rd_i   (c_rd_o),
    .c_wr_i   (c_wr_o)
);

`default_nettype wire

//--- verilog/ntt_pw_top.sv
`timescale 1ns/1ps
`default_nettype none

module ntt_pw_top #(
    parameter int NUM_WORDS = 64
) (
    input  wire                          clk,
    input  wire                          reset_n,

    // APB slave
    input  wire                          psel_i,
    input  wire                          penable_i,
    input  wire                          pwrite_i,
    input  wire ntt_pw_pkg::apb_addr_t   paddr_i,
    input  wire ntt_pw_pkg::apb_data_t   pwdata_i,
    output ntt_pw_pkg::apb_data_t        prdata_o,
    output logic                         pready_o,
    output logic                         pslverr_o,

    // Operand and result memories
    output ntt_pw_pkg::mem_req_t         a_rd_o,
    output ntt_pw_pkg::mem_req_t         b_rd_o,
    output ntt_pw_pkg::mem_req_t         c_rd_o,
    input  wire ntt_pw_pkg::mem_word_t   a_data_i,
    input  wire ntt_pw_pkg::mem_word_t   b_data_i,
    input  wire ntt_pw_pkg::mem_word_t   c_data_i,
    output ntt_pw_pkg::mem_req_t         c_wr_o,
    output ntt_pw_pkg::mem_word_t        c_wr_data_o,

    output logic                         done_o
);

    logic                                        start;
    ntt_pw_pkg::pw_cfg_t                         cfg;
    ntt_pw_pkg::pw_tag_t                         tag;
    ntt_pw_pkg::coeff_t [ntt_pw_pkg::LANES-1:0]  lane_r;

    pw_apb_regs u_regs (
        .clk       (clk),
        .reset_n   (reset_n),
        .psel_i    (psel_i),
        .penable_i (penable_i),
        .pwrite_i  (pwrite_i),
        .paddr_i   (paddr_i),
        .pwdata_i  (pwdata_i),
        .prdata_o  (prdata_o),
        .pready_o  (pready_o),
        .pslverr_o (pslverr_o),
        .done_i    (done_o),
        .start_o   (start),
        .cfg_o     (cfg)
    );

    pw_sequencer #(
        .NUM_WORDS (NUM_WORDS)
    ) u_seq (
        .clk     (clk),
        .reset_n (reset_n),
        .start_i (start),
        .cfg_i   (cfg),
        .a_rd_o  (a_rd_o),
        .b_rd_o  (b_rd_o),
        .c_rd_o  (c_rd_o),
        .tag_o   (tag)
    );

    // One lane per coefficient slot, top slot bit dropped
    for (genvar i = 0; i < ntt_pw_pkg::LANES; i++) begin : gen_lane
        pw_mod_lane u_lane (
            .clk     (clk),
            .reset_n (reset_n),
            .op_i    (tag.op),
            .a_i     (a_data_i[i*ntt_pw_pkg::SLOT_W +: ntt_pw_pkg::COEFF_W]),
            .b_i     (b_data_i[i*ntt_pw_pkg::SLOT_W +: ntt_pw_pkg::COEFF_W]),
            .c_i     (c_data_i[i*ntt_pw_pkg::SLOT_W +: ntt_pw_pkg::COEFF_W]),
            .r_o     (lane_r[i])
        );
    end

    pw_writeback u_wb (
        .clk         (clk),
        .reset_n     (reset_n),
        .tag_i       (tag),
        .r_i         (lane_r),
        .c_wr_o      (c_wr_o),
        .c_wr_data_o (c_wr_data_o),
        .done_o      (done_o)
    );

endmodule

`default_nettype wire

//--- verilog/pw_writeback.sv
`timescale 1ns/1ps
`default_nettype none

module pw_writeback (
    input  wire                                        clk,
    input  wire                                        reset_n,
    input  wire ntt_pw_pkg::pw_tag_t                   tag_i,
    input  wire ntt_pw_pkg::coeff_t [ntt_pw_pkg::LANES-1:0] r_i,
    output ntt_pw_pkg::mem_req_t                       c_wr_o,
    output ntt_pw_pkg::mem_word_t                      c_wr_data_o,
    output logic                                       done_o
);

    localparam int PAD_W = ntt_pw_pkg::SLOT_W - ntt_pw_pkg::COEFF_W;

    ntt_pw_pkg::pw_tag_t    tag_d1;
    ntt_pw_pkg::pw_tag_t    tag_d2;
    ntt_pw_pkg::mem_word_t  word;
    logic                   wr_last_q;

    // Match the two-cycle lane latency
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            tag_d1 <= '0;
            tag_d2 <= '0;
        end else begin
            tag_d1 <= tag_i;
            tag_d2 <= tag_d1;
        end
    end

    // Zero-pad each coefficient into its slot
    always_comb begin
        for (int i = 0; i < ntt_pw_pkg::LANES; i++) begin
            word[i*ntt_pw_pkg::SLOT_W +: ntt_pw_pkg::SLOT_W] = {{PAD_W{1'b0}}, r_i[i]};
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            c_wr_o    <= '0;
            wr_last_q <= 1'b0;
            done_o    <= 1'b0;
        end else begin
            c_wr_o.en   <= tag_d2.valid;
            c_wr_o.addr <= tag_d2.wr_addr;
            wr_last_q   <= tag_d2.valid & tag_d2.last;
            // Done follows the final write by one cycle
            done_o      <= wr_last_q;
        end
    end

    always_ff @(posedge clk) begin
        c_wr_data_o <= word;
    end

endmodule

`default_nettype wire

//--- verilog/pw_mod_lane.sv
`timescale 1ns/1ps
`default_nettype none

module pw_mod_lane (
    input  wire                          clk,
    input  wire                          reset_n,
    input  wire ntt_pw_pkg::pw_op_e      op_i,
    input  wire ntt_pw_pkg::coeff_t      a_i,
    input  wire ntt_pw_pkg::coeff_t      b_i,
    input  wire ntt_pw_pkg::coeff_t      c_i,
    output ntt_pw_pkg::coeff_t           r_o
);

    localparam int W      = ntt_pw_pkg::COEFF_W;
    localparam int PROD_W = 2 * W;
    localparam ntt_pw_pkg::coeff_t Q = ntt_pw_pkg::coeff_t'(ntt_pw_pkg::PW_Q);

    logic [PROD_W-1:0]   s1_val;
    ntt_pw_pkg::coeff_t  s1_c;
    ntt_pw_pkg::pw_op_e  s1_op;
    logic [36:0]         fold1;
    logic [27:0]         fold2;
    logic [W+1:0]        fold3;
    logic [W+1:0]        sum;

    // Stage one: product, sum, or difference lifted by q
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            s1_op <= ntt_pw_pkg::OP_MUL;
        end else begin
            s1_op <= op_i;
        end
    end

    always_ff @(posedge clk) begin
        s1_c <= c_i;
        case (op_i)
            ntt_pw_pkg::OP_ADD: s1_val <= PROD_W'(a_i) + PROD_W'(b_i);
            ntt_pw_pkg::OP_SUB: s1_val <= PROD_W'(a_i) + PROD_W'(Q) - PROD_W'(b_i);
            default:            s1_val <= PROD_W'(a_i) * PROD_W'(b_i);
        endcase
    end

    // Stage two: 2^23 = 2^13 - 1 mod q, three folds leave the value below 2q
    always_comb begin
        fold1 = 37'(s1_val[W-1:0]) + (37'(s1_val[PROD_W-1:W]) << 13)
              - 37'(s1_val[PROD_W-1:W]);
        fold2 = 28'(fold1[W-1:0]) + (28'(fold1[36:W]) << 13) - 28'(fold1[36:W]);
        fold3 = (W+2)'(fold2[W-1:0]) + ((W+2)'(fold2[27:W]) << 13)
              - (W+2)'(fold2[27:W]);

        case (s1_op)
            ntt_pw_pkg::OP_MUL:    sum = fold3;
            ntt_pw_pkg::OP_MULACC: sum = fold3 + (W+2)'(s1_c);
            default:               sum = (W+2)'(s1_val[W:0]);
        endcase

        // Accumulate can reach 3q, so subtract up to twice
        if (sum >= (W+2)'(Q)) begin
            sum = sum - (W+2)'(Q);
        end
        if (sum >= (W+2)'(Q)) begin
            sum = sum - (W+2)'(Q);
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            r_o <= '0;
        end else begin
            r_o <= sum[W-1:0];
        end
    end

endmodule

`default_nettype wire

//--- verilog/pw_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module pw_sequencer #(
    parameter int NUM_WORDS = 64
) (
    input  wire                          clk,
    input  wire                          reset_n,
    input  wire                          start_i,
    input  wire ntt_pw_pkg::pw_cfg_t     cfg_i,
    output ntt_pw_pkg::mem_req_t         a_rd_o,
    output ntt_pw_pkg::mem_req_t         b_rd_o,
    output ntt_pw_pkg::mem_req_t         c_rd_o,
    output ntt_pw_pkg::pw_tag_t          tag_o
);

    ntt_pw_pkg::seq_state_e  state_q;
    ntt_pw_pkg::mem_addr_t   offset_q;
    ntt_pw_pkg::pw_op_e      op_q;
    ntt_pw_pkg::pw_op_e      op_dec;
    ntt_pw_pkg::pw_tag_t     tag_q;
    logic                    reading;
    logic                    last_word;

    // Mode plus accumulate flag to lane op
    always_comb begin
        case (cfg_i.mode)
            ntt_pw_pkg::PW_ADD: op_dec = ntt_pw_pkg::OP_ADD;
            ntt_pw_pkg::PW_SUB: op_dec = ntt_pw_pkg::OP_SUB;
            default: begin
                op_dec = cfg_i.accumulate ? ntt_pw_pkg::OP_MULACC : ntt_pw_pkg::OP_MUL;
            end
        endcase
    end

    assign reading   = (state_q == ntt_pw_pkg::RUN);
    assign last_word = (offset_q == ntt_pw_pkg::mem_addr_t'(NUM_WORDS - 1));

    // ========================================================================
    // Word counter FSM
    // ========================================================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q  <= ntt_pw_pkg::IDLE;
            offset_q <= '0;
            op_q     <= ntt_pw_pkg::OP_MUL;
        end else begin
            case (state_q)
                ntt_pw_pkg::IDLE: begin
                    if (start_i) begin
                        state_q  <= ntt_pw_pkg::RUN;
                        offset_q <= '0;
                        op_q     <= op_dec;
                    end
                end
                ntt_pw_pkg::RUN: begin
                    if (last_word) begin
                        state_q <= ntt_pw_pkg::DRAIN;
                    end else begin
                        offset_q <= offset_q + 1'b1;
                    end
                end
                // Last tag leaves this cycle
                ntt_pw_pkg::DRAIN: state_q <= ntt_pw_pkg::IDLE;
                default:           state_q <= ntt_pw_pkg::IDLE;
            endcase
        end
    end

    // One read per cycle, c only needed when accumulating
    always_comb begin
        a_rd_o.en   = reading;
        a_rd_o.addr = cfg_i.a_base + offset_q;
        b_rd_o.en   = reading;
        b_rd_o.addr = cfg_i.b_base + offset_q;
        c_rd_o.en   = reading & (op_q == ntt_pw_pkg::OP_MULACC);
        c_rd_o.addr = cfg_i.c_base + offset_q;
    end

    // Tag lines up with data returning from the memories
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            tag_q <= '0;
        end else begin
            tag_q.valid   <= reading;
            tag_q.op      <= op_q;
            tag_q.last    <= reading & last_word;
            tag_q.wr_addr <= cfg_i.c_base + offset_q;
        end
    end

    assign tag_o = tag_q;

endmodule

`default_nettype wire

//--- verilog/pw_apb_regs.sv
`timescale 1ns/1ps
`default_nettype none

module pw_apb_regs (
    input  wire                          clk,
    input  wire                          reset_n,
    input  wire                          psel_i,
    input  wire                          penable_i,
    input  wire                          pwrite_i,
    input  wire ntt_pw_pkg::apb_addr_t   paddr_i,
    input  wire ntt_pw_pkg::apb_data_t   pwdata_i,
    output ntt_pw_pkg::apb_data_t        prdata_o,
    output logic                         pready_o,
    output logic                         pslverr_o,
    input  wire                          done_i,
    output logic                         start_o,
    output ntt_pw_pkg::pw_cfg_t          cfg_o
);

    logic                    access;
    logic                    wr_en;
    logic                    mapped;
    logic                    busy_q;
    logic                    done_q;
    ntt_pw_pkg::pw_cfg_t     cfg_q;
    ntt_pw_pkg::apb_data_t   rdata;

    // No wait states, access cycle is the one with penable
    assign access   = psel_i & penable_i;
    assign wr_en    = access & pwrite_i;
    assign pready_o = 1'b1;

    // ========================================================================
    // Read decode
    // ========================================================================
    always_comb begin
        mapped = 1'b1;
        rdata  = '0;
        case (paddr_i)
            ntt_pw_pkg::REG_CTRL:   rdata[3:1] = {cfg_q.accumulate, cfg_q.mode};
            ntt_pw_pkg::REG_STATUS: rdata[1:0] = {done_q, busy_q};
            ntt_pw_pkg::REG_A_BASE: rdata[ntt_pw_pkg::ADDR_W-1:0] = cfg_q.a_base;
            ntt_pw_pkg::REG_B_BASE: rdata[ntt_pw_pkg::ADDR_W-1:0] = cfg_q.b_base;
            ntt_pw_pkg::REG_C_BASE: rdata[ntt_pw_pkg::ADDR_W-1:0] = cfg_q.c_base;
            default:                mapped = 1'b0;
        endcase
    end

    assign prdata_o  = (psel_i & ~pwrite_i) ? rdata : '0;
    assign pslverr_o = access & ~mapped;

    // ========================================================================
    // Configuration, start and status
    // ========================================================================

    // Config frozen while a run is in progress
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            cfg_q <= '0;
        end else if (wr_en && !busy_q) begin
            case (paddr_i)
                ntt_pw_pkg::REG_CTRL: begin
                    cfg_q.mode       <= ntt_pw_pkg::pw_mode_e'(pwdata_i[2:1]);
                    cfg_q.accumulate <= pwdata_i[3];
                end
                ntt_pw_pkg::REG_A_BASE: cfg_q.a_base <= pwdata_i[ntt_pw_pkg::ADDR_W-1:0];
                ntt_pw_pkg::REG_B_BASE: cfg_q.b_base <= pwdata_i[ntt_pw_pkg::ADDR_W-1:0];
                ntt_pw_pkg::REG_C_BASE: cfg_q.c_base <= pwdata_i[ntt_pw_pkg::ADDR_W-1:0];
                default: ;
            endcase
        end
    end

    // Start is write-one on CTRL bit 0, busy rises with it
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            start_o <= 1'b0;
            busy_q  <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            start_o <= wr_en & (paddr_i == ntt_pw_pkg::REG_CTRL) & pwdata_i[0] & ~busy_q;
            if (start_o) begin
                done_q <= 1'b0;
            end else if (done_i) begin
                busy_q <= 1'b0;
                done_q <= 1'b1;
            end
            if (wr_en && (paddr_i == ntt_pw_pkg::REG_CTRL) && pwdata_i[0] && !busy_q) begin
                busy_q <= 1'b1;
            end
        end
    end

    assign cfg_o = cfg_q;

endmodule

`default_nettype wire

//--- verilog/ntt_pw_pkg.sv
`default_nettype none

package ntt_pw_pkg;

    // ========================================================================
    // Field and memory geometry
    // ========================================================================

    // ML-DSA modulus
    localparam logic [31:0] PW_Q = 32'd8380417;

    localparam int COEFF_W = 23;
    localparam int SLOT_W  = 24;
    localparam int LANES   = 4;
    localparam int ADDR_W  = 15;

    typedef logic [COEFF_W-1:0]      coeff_t;
    typedef logic [LANES*SLOT_W-1:0] mem_word_t;
    typedef logic [ADDR_W-1:0]       mem_addr_t;
    typedef logic [7:0]              apb_addr_t;
    typedef logic [31:0]             apb_data_t;

    // APB register map
    localparam apb_addr_t REG_CTRL   = 8'h00;
    localparam apb_addr_t REG_STATUS = 8'h04;
    localparam apb_addr_t REG_A_BASE = 8'h08;
    localparam apb_addr_t REG_B_BASE = 8'h0C;
    localparam apb_addr_t REG_C_BASE = 8'h10;

    // ========================================================================
    // Operations and states
    // ========================================================================

    typedef enum logic [1:0] {
        PW_MUL = 2'd0,
        PW_ADD = 2'd1,
        PW_SUB = 2'd2
    } pw_mode_e;

    // What one lane does with one word
    typedef enum logic [1:0] {
        OP_MUL    = 2'd0,
        OP_MULACC = 2'd1,
        OP_ADD    = 2'd2,
        OP_SUB    = 2'd3
    } pw_op_e;

    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        RUN   = 2'd1,
        DRAIN = 2'd2
    } seq_state_e;

    typedef struct packed {
        logic      en;
        mem_addr_t addr;
    } mem_req_t;

    typedef struct packed {
        pw_mode_e  mode;
        logic      accumulate;
        mem_addr_t a_base;
        mem_addr_t b_base;
        mem_addr_t c_base;
    } pw_cfg_t;

    // One word in flight, travels alongside the read data
    typedef struct packed {
        logic      valid;
        pw_op_e    op;
        logic      last;
        mem_addr_t wr_addr;
    } pw_tag_t;

endpackage

`default_nettype wire
